//--- design/com_pkg.sv
package com_pkg;

    // ==============================
    // widths
    // ==============================
    localparam int REG_AW    = 7;
    localparam int REG_DW    = 8;
    localparam int REG_CRC_W = 8;

    // ==============================
    // register map
    // ==============================
    localparam logic [REG_AW-1:0] ADDR_ID      = 7'h00;
    localparam logic [REG_AW-1:0] ADDR_MODE    = 7'h01;
    localparam logic [REG_AW-1:0] ADDR_CONFIG1 = 7'h02;
    localparam logic [REG_AW-1:0] ADDR_CONFIG2 = 7'h03;
    localparam logic [REG_AW-1:0] ADDR_STATUS1 = 7'h08;
    localparam logic [REG_AW-1:0] ADDR_MASK1   = 7'h09;
    localparam logic [REG_AW-1:0] ADDR_STATUS2 = 7'h0A;
    localparam logic [REG_AW-1:0] ADDR_MASK2   = 7'h0B;

    localparam logic [REG_DW-1:0] DEVICE_ID = 8'h53;

    // defaults, data and check byte
    localparam logic [REG_DW-1:0]    MODE_RST        = 8'h10;
    localparam logic [REG_CRC_W-1:0] MODE_CRC_RST    = 8'h02;
    localparam logic [REG_DW-1:0]    CONFIG1_RST     = 8'h2B;
    localparam logic [REG_CRC_W-1:0] CONFIG1_CRC_RST = 8'h17;
    localparam logic [REG_DW-1:0]    CONFIG2_RST     = 8'hFF;
    localparam logic [REG_CRC_W-1:0] CONFIG2_CRC_RST = 8'hE9;
    localparam logic [REG_DW-1:0]    MASK1_RST       = 8'h00;
    localparam logic [REG_CRC_W-1:0] MASK1_CRC_RST   = 8'hD3;
    localparam logic [REG_DW-1:0]    MASK2_RST       = 8'h00;
    localparam logic [REG_CRC_W-1:0] MASK2_CRC_RST   = 8'h2E;

    // ==============================
    // types
    // ==============================
    typedef enum logic [1:0] {
        ACC_NONE,
        ACC_TEST,
        ACC_CFG,
        ACC_SPI
    } acc_state_e;

    typedef enum logic [3:0] {
        SEL_NONE,
        SEL_ID,
        SEL_MODE,
        SEL_CONFIG1,
        SEL_CONFIG2,
        SEL_STATUS1,
        SEL_MASK1,
        SEL_STATUS2,
        SEL_MASK2
    } reg_sel_e;

    typedef struct packed {
        logic                 ren;
        logic                 wen;
        logic [REG_AW-1:0]    addr;
        logic [REG_DW-1:0]    wdata;
        logic [REG_CRC_W-1:0] wcrc;
    } spi_req_t;

    typedef struct packed {
        logic                 wack;
        logic                 rack;
        logic [REG_DW-1:0]    rdata;
        logic [REG_CRC_W-1:0] rcrc;
    } spi_rsp_t;

    // one strobe per writable register
    typedef struct packed {
        logic                 mode;
        logic                 config1;
        logic                 config2;
        logic                 mask1;
        logic                 mask2;
        logic                 status1;
        logic                 status2;
        logic [REG_DW-1:0]    wdata;
        logic [REG_CRC_W-1:0] wcrc;
    } reg_wr_t;

    typedef struct packed {
        logic [REG_DW-1:0] mode;
        logic [REG_DW-1:0] config1;
        logic [REG_DW-1:0] config2;
        logic [REG_DW-1:0] mask1;
        logic [REG_DW-1:0] mask2;
    } cfg_regs_t;

    typedef struct packed {
        logic [REG_CRC_W-1:0] mode;
        logic [REG_CRC_W-1:0] config1;
        logic [REG_CRC_W-1:0] config2;
        logic [REG_CRC_W-1:0] mask1;
        logic [REG_CRC_W-1:0] mask2;
    } cfg_crc_t;

    typedef struct packed {
        logic [REG_DW-1:0] status1;
        logic [REG_DW-1:0] status2;
    } status_regs_t;

    typedef struct packed {
        logic [REG_DW-1:0] status1;
        logic [REG_DW-1:0] status2;
    } int_event_t;

endpackage

//--- design/rstn_merge.sv
`timescale 1ns/1ps

module rstn_merge (
    input  logic i_clk,
    input  logic i_rst_n,
    input  logic i_soft_rst,
    output logic o_rst_n
);

    logic       src_rst_n;
    logic [1:0] sync_q;

    // either source pulls the block into reset at once
    assign src_rst_n = i_rst_n & ~i_soft_rst;

    // release after two flops
    always_ff @(posedge i_clk or negedge src_rst_n) begin
        if (!src_rst_n) begin
            sync_q <= 2'b00;
        end else begin
            sync_q <= {sync_q[0], 1'b1};
        end
    end

    assign o_rst_n = sync_q[1];

endmodule

//--- design/reg_access_decode.sv
`timescale 1ns/1ps

module reg_access_decode (
    input  com_pkg::spi_req_t i_spi_req,
    input  logic              i_test_st_reg_en,
    input  logic              i_cfg_st_reg_en,
    input  logic              i_spi_ctrl_reg_en,
    output com_pkg::reg_wr_t  o_reg_wr,
    output com_pkg::reg_sel_e o_rd_sel,
    output logic              o_ren,
    output logic              o_wen
);
    import com_pkg::*;

    acc_state_e acc_state;
    reg_sel_e   addr_sel;
    logic       rd_ok;
    logic       wr_mode_ok;
    logic       wr_cfg_ok;
    logic       wr_sts_ok;
    logic       wen;

    // test wins over config, config over serial control
    always_comb begin
        if (i_test_st_reg_en) begin
            acc_state = ACC_TEST;
        end else if (i_cfg_st_reg_en) begin
            acc_state = ACC_CFG;
        end else if (i_spi_ctrl_reg_en) begin
            acc_state = ACC_SPI;
        end else begin
            acc_state = ACC_NONE;
        end
    end

    always_comb begin
        case (i_spi_req.addr)
            ADDR_ID:      addr_sel = SEL_ID;
            ADDR_MODE:    addr_sel = SEL_MODE;
            ADDR_CONFIG1: addr_sel = SEL_CONFIG1;
            ADDR_CONFIG2: addr_sel = SEL_CONFIG2;
            ADDR_STATUS1: addr_sel = SEL_STATUS1;
            ADDR_MASK1:   addr_sel = SEL_MASK1;
            ADDR_STATUS2: addr_sel = SEL_STATUS2;
            ADDR_MASK2:   addr_sel = SEL_MASK2;
            default:      addr_sel = SEL_NONE;
        endcase
    end

    // ==============================
    // permissions per register class
    // ==============================
    assign rd_ok      = (acc_state == ACC_TEST) || (acc_state == ACC_SPI);
    assign wr_mode_ok = (acc_state != ACC_NONE);
    assign wr_cfg_ok  = (acc_state == ACC_TEST) || (acc_state == ACC_CFG);
    assign wr_sts_ok  = (acc_state == ACC_CFG) || (acc_state == ACC_SPI);

    assign wen = i_spi_req.wen;

    // unmapped or denied reads fall to none
    assign o_rd_sel = (i_spi_req.ren && rd_ok) ? addr_sel : SEL_NONE;

    assign o_reg_wr.mode    = wen && wr_mode_ok && (addr_sel == SEL_MODE);
    assign o_reg_wr.config1 = wen && wr_cfg_ok && (addr_sel == SEL_CONFIG1);
    assign o_reg_wr.config2 = wen && wr_cfg_ok && (addr_sel == SEL_CONFIG2);
    assign o_reg_wr.mask1   = wen && wr_cfg_ok && (addr_sel == SEL_MASK1);
    assign o_reg_wr.mask2   = wen && wr_cfg_ok && (addr_sel == SEL_MASK2);
    assign o_reg_wr.status1 = wen && wr_sts_ok && (addr_sel == SEL_STATUS1);
    assign o_reg_wr.status2 = wen && wr_sts_ok && (addr_sel == SEL_STATUS2);
    assign o_reg_wr.wdata   = i_spi_req.wdata;
    assign o_reg_wr.wcrc    = i_spi_req.wcrc;

    // every strobe is acknowledged, permitted or not
    assign o_ren = i_spi_req.ren;
    assign o_wen = wen;

endmodule

//--- design/cfg_reg_file.sv
`timescale 1ns/1ps

module cfg_reg_file (
    input  logic               i_clk,
    input  logic               i_rst_n,
    input  logic               i_blk_rst_n,
    input  com_pkg::reg_wr_t   i_reg_wr,
    output com_pkg::cfg_regs_t o_cfg_regs,
    output com_pkg::cfg_crc_t  o_cfg_crc
);
    import com_pkg::*;

    logic              mode_srst_q;
    logic [REG_DW-1:1] mode_hi_q;
    logic [REG_DW-1:0] config1_q;
    logic [REG_DW-1:0] config2_q;
    logic [REG_DW-1:0] mask1_q;
    logic [REG_DW-1:0] mask2_q;
    cfg_crc_t          crc_q;

    // ==============================
    // software reset bit
    // ==============================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            mode_srst_q <= MODE_RST[0];
        end else if (i_reg_wr.mode) begin
            mode_srst_q <= i_reg_wr.wdata[0];
        end
    end

    // ==============================
    // block reset domain
    // ==============================
    always_ff @(posedge i_clk or negedge i_blk_rst_n) begin
        if (!i_blk_rst_n) begin
            mode_hi_q     <= MODE_RST[REG_DW-1:1];
            config1_q     <= CONFIG1_RST;
            config2_q     <= CONFIG2_RST;
            mask1_q       <= MASK1_RST;
            mask2_q       <= MASK2_RST;
            crc_q.mode    <= MODE_CRC_RST;
            crc_q.config1 <= CONFIG1_CRC_RST;
            crc_q.config2 <= CONFIG2_CRC_RST;
            crc_q.mask1   <= MASK1_CRC_RST;
            crc_q.mask2   <= MASK2_CRC_RST;
        end else begin
            if (i_reg_wr.mode) begin
                mode_hi_q  <= i_reg_wr.wdata[REG_DW-1:1];
                crc_q.mode <= i_reg_wr.wcrc;
            end
            if (i_reg_wr.config1) begin
                config1_q     <= i_reg_wr.wdata;
                crc_q.config1 <= i_reg_wr.wcrc;
            end
            if (i_reg_wr.config2) begin
                config2_q     <= i_reg_wr.wdata;
                crc_q.config2 <= i_reg_wr.wcrc;
            end
            if (i_reg_wr.mask1) begin
                mask1_q     <= i_reg_wr.wdata;
                crc_q.mask1 <= i_reg_wr.wcrc;
            end
            if (i_reg_wr.mask2) begin
                mask2_q     <= i_reg_wr.wdata;
                crc_q.mask2 <= i_reg_wr.wcrc;
            end
        end
    end

    assign o_cfg_regs.mode    = {mode_hi_q, mode_srst_q};
    assign o_cfg_regs.config1 = config1_q;
    assign o_cfg_regs.config2 = config2_q;
    assign o_cfg_regs.mask1   = mask1_q;
    assign o_cfg_regs.mask2   = mask2_q;
    assign o_cfg_crc          = crc_q;

endmodule

//--- design/status_reg_file.sv
`timescale 1ns/1ps

module status_reg_file (
    input  logic                  i_clk,
    input  logic                  i_blk_rst_n,
    input  com_pkg::reg_wr_t      i_reg_wr,
    input  com_pkg::int_event_t   i_int_event,
    output com_pkg::status_regs_t o_status_regs
);
    import com_pkg::*;

    status_regs_t      status_q;
    status_regs_t      status_d;
    logic [REG_DW-1:0] clr1;
    logic [REG_DW-1:0] clr2;

    // write one to clear
    assign clr1 = {REG_DW{i_reg_wr.status1}} & i_reg_wr.wdata;
    assign clr2 = {REG_DW{i_reg_wr.status2}} & i_reg_wr.wdata;

    // set wins over a clear of the same bit
    always_comb begin
        status_d.status1 = (status_q.status1 & ~clr1) | i_int_event.status1;
        status_d.status2 = (status_q.status2 & ~clr2) | i_int_event.status2;
    end

    always_ff @(posedge i_clk or negedge i_blk_rst_n) begin
        if (!i_blk_rst_n) begin
            status_q <= '0;
        end else begin
            status_q <= status_d;
        end
    end

    assign o_status_regs = status_q;

endmodule

//--- design/spi_response.sv
`timescale 1ns/1ps

module spi_response (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_ren,
    input  logic                  i_wen,
    input  com_pkg::reg_sel_e     i_rd_sel,
    input  com_pkg::cfg_regs_t    i_cfg_regs,
    input  com_pkg::cfg_crc_t     i_cfg_crc,
    input  com_pkg::status_regs_t i_status_regs,
    output com_pkg::spi_rsp_t     o_spi_rsp
);
    import com_pkg::*;

    logic [REG_DW-1:0]    rd_data;
    logic [REG_CRC_W-1:0] rd_crc;
    spi_rsp_t             rsp_q;

    // identifier and status carry no check byte
    always_comb begin
        rd_data = '0;
        rd_crc  = '0;
        case (i_rd_sel)
            SEL_ID: begin
                rd_data = DEVICE_ID;
            end
            SEL_MODE: begin
                rd_data = i_cfg_regs.mode;
                rd_crc  = i_cfg_crc.mode;
            end
            SEL_CONFIG1: begin
                rd_data = i_cfg_regs.config1;
                rd_crc  = i_cfg_crc.config1;
            end
            SEL_CONFIG2: begin
                rd_data = i_cfg_regs.config2;
                rd_crc  = i_cfg_crc.config2;
            end
            SEL_MASK1: begin
                rd_data = i_cfg_regs.mask1;
                rd_crc  = i_cfg_crc.mask1;
            end
            SEL_MASK2: begin
                rd_data = i_cfg_regs.mask2;
                rd_crc  = i_cfg_crc.mask2;
            end
            SEL_STATUS1: rd_data = i_status_regs.status1;
            SEL_STATUS2: rd_data = i_status_regs.status2;
            default: ;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            rsp_q <= '0;
        end else begin
            rsp_q.wack  <= i_wen;
            rsp_q.rack  <= i_ren;
            rsp_q.rdata <= rd_data;
            rsp_q.rcrc  <= rd_crc;
        end
    end

    assign o_spi_rsp = rsp_q;

endmodule

//--- design/com_reg_bank.sv
`timescale 1ns/1ps

module com_reg_bank (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  com_pkg::spi_req_t     i_spi_req,
    input  logic                  i_test_st_reg_en,
    input  logic                  i_cfg_st_reg_en,
    input  logic                  i_spi_ctrl_reg_en,
    input  com_pkg::int_event_t   i_int_event,
    output com_pkg::spi_rsp_t     o_spi_rsp,
    output com_pkg::cfg_regs_t    o_cfg_regs,
    output com_pkg::status_regs_t o_status_regs,
    output logic                  o_rst_n
);
    import com_pkg::*;

    reg_wr_t      reg_wr;
    reg_sel_e     rd_sel;
    logic         ren;
    logic         wen;
    cfg_regs_t    cfg_regs;
    cfg_crc_t     cfg_crc;
    status_regs_t status_regs;
    logic         blk_rst_n;

    // ==============================
    // access control
    // ==============================
    reg_access_decode u_decode (
        .i_spi_req         (i_spi_req),
        .i_test_st_reg_en  (i_test_st_reg_en),
        .i_cfg_st_reg_en   (i_cfg_st_reg_en),
        .i_spi_ctrl_reg_en (i_spi_ctrl_reg_en),
        .o_reg_wr          (reg_wr),
        .o_rd_sel          (rd_sel),
        .o_ren             (ren),
        .o_wen             (wen)
    );

    // ==============================
    // register files
    // ==============================
    cfg_reg_file u_cfg (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_blk_rst_n (blk_rst_n),
        .i_reg_wr    (reg_wr),
        .o_cfg_regs  (cfg_regs),
        .o_cfg_crc   (cfg_crc)
    );

    status_reg_file u_status (
        .i_clk         (i_clk),
        .i_blk_rst_n   (blk_rst_n),
        .i_reg_wr      (reg_wr),
        .i_int_event   (i_int_event),
        .o_status_regs (status_regs)
    );

    spi_response u_rsp (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_ren         (ren),
        .i_wen         (wen),
        .i_rd_sel      (rd_sel),
        .i_cfg_regs    (cfg_regs),
        .i_cfg_crc     (cfg_crc),
        .i_status_regs (status_regs),
        .o_spi_rsp     (o_spi_rsp)
    );

    // mode bit 0 is the software reset
    rstn_merge u_rst (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_soft_rst (cfg_regs.mode[0]),
        .o_rst_n    (blk_rst_n)
    );

    assign o_cfg_regs    = cfg_regs;
    assign o_status_regs = status_regs;
    assign o_rst_n       = blk_rst_n;

endmodule

//--- testbench/tb_com_reg_bank.sv
`timescale 1ns/1ps

module tb_com_reg_bank;
    import com_pkg::*;

    localparam int TIMEOUT = 20;

    logic         clk;
    logic         rst_n;
    spi_req_t     spi_req;
    logic         test_en;
    logic         cfg_en;
    logic         spi_en;
    int_event_t   int_event;
    spi_rsp_t     spi_rsp;
    cfg_regs_t    cfg_regs;
    status_regs_t status_regs;
    logic         blk_rst_n;
    int_event_t   pend_ev;

    com_reg_bank dut_i (
        .i_clk             (clk),
        .i_rst_n           (rst_n),
        .i_spi_req         (spi_req),
        .i_test_st_reg_en  (test_en),
        .i_cfg_st_reg_en   (cfg_en),
        .i_spi_ctrl_reg_en (spi_en),
        .i_int_event       (int_event),
        .o_spi_rsp         (spi_rsp),
        .o_cfg_regs        (cfg_regs),
        .o_status_regs     (status_regs),
        .o_rst_n           (blk_rst_n)
    );

    always #4 clk = ~clk;

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("FAIL %0t: %s, got %0h, expected %0h", $time, what, actual, expected);
            $display("test failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic fail_timeout(input string what);
        $display("timed out while waiting for %s", what);
        $display("test failed");
        $fatal(1, "timeout");
    endtask

    // 0 none, 1 test, 2 config, 3 serial control
    task automatic set_state(input logic [1:0] st);
        test_en = (st == 2'd1);
        cfg_en  = (st == 2'd2);
        spi_en  = (st == 2'd3);
    endtask

    function automatic logic [7:0] cfg_field(input logic [31:0] idx);
        case (idx)
            0:       return cfg_regs.mode;
            1:       return cfg_regs.config1;
            2:       return cfg_regs.config2;
            3:       return cfg_regs.mask1;
            4:       return cfg_regs.mask2;
            default: return 8'h00;
        endcase
    endfunction

    task automatic run_access(input logic is_rd, input logic [1:0] st, input logic [6:0] addr,
                              input logic [7:0] data, input logic [7:0] crc);
        int   waited;
        logic ack;
        @(negedge clk);
        set_state(st);
        spi_req.ren   = is_rd;
        spi_req.wen   = !is_rd;
        spi_req.addr  = addr;
        spi_req.wdata = is_rd ? 8'h00 : data;
        spi_req.wcrc  = is_rd ? 8'h00 : crc;
        int_event     = pend_ev;
        pend_ev       = '0;
        @(negedge clk);
        spi_req.ren = 1'b0;
        spi_req.wen = 1'b0;
        int_event   = '0;
        waited      = 0;
        ack         = is_rd ? spi_rsp.rack : spi_rsp.wack;
        while (!ack && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
            ack = is_rd ? spi_rsp.rack : spi_rsp.wack;
        end
        if (!ack) begin
            fail_timeout(is_rd ? "read acknowledge" : "write acknowledge");
        end else begin
            check_value(waited, 0, "acknowledge latency");
            check_value(is_rd ? spi_rsp.wack : spi_rsp.rack, 0, "unexpected acknowledge");
            if (is_rd) begin
                check_value(spi_rsp.rdata, data, $sformatf("read data at %0h", addr));
                check_value(spi_rsp.rcrc, crc, $sformatf("read check byte at %0h", addr));
            end
            // pulse lasts a single cycle
            @(negedge clk);
            check_value(spi_rsp.wack | spi_rsp.rack, 0, "acknowledge pulse width");
        end
    endtask

    task automatic run_idle(input logic [31:0] cycles);
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            int_event = (i == 0) ? pend_ev : '0;
        end
        pend_ev = '0;
        @(negedge clk);
        int_event = '0;
    endtask

    task automatic wait_rst_level(input logic level);
        int waited;
        waited = 0;
        while (blk_rst_n !== level && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (blk_rst_n !== level) begin
            fail_timeout("block reset level");
        end
    endtask

    task automatic run_op(input logic [7:0] op, input logic [31:0] f1, input logic [31:0] f2,
                          input logic [31:0] f3, input logic [31:0] f4);
        case (op)
            "W": run_access(1'b0, f1[1:0], f2[6:0], f3[7:0], f4[7:0]);
            "R": run_access(1'b1, f1[1:0], f2[6:0], f3[7:0], f4[7:0]);
            "E": pend_ev = {f1[7:0], f2[7:0]};
            "G": check_value(cfg_field(f1), f2, $sformatf("config output %0d", f1));
            "X": wait_rst_level(f1[0]);
            "I": run_idle(f1);
            "S": begin
                check_value(status_regs.status1, f1, "status1 output");
                check_value(status_regs.status2, f2, "status2 output");
            end
            default: begin
                $display("unknown operation in trace file");
                $display("test failed");
                $fatal(1, "bad trace");
            end
        endcase
    endtask

    initial begin
        int          fd;
        int          c;
        logic [7:0]  op;
        logic [31:0] f1;
        logic [31:0] f2;
        logic [31:0] f3;
        logic [31:0] f4;
        clk       = 1'b0;
        rst_n     = 1'b0;
        spi_req   = '0;
        int_event = '0;
        pend_ev   = '0;
        set_state(2'd0);
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_value(blk_rst_n, 0, "block reset right after release");
        check_value(spi_rsp.wack | spi_rsp.rack, 0, "acknowledge after reset");
        fd = $fopen("testbench/com_reg_bank_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open the trace file");
            $display("test failed");
            $fatal(1, "no trace");
        end else begin
            while ($fscanf(fd, " %c", op) == 1) begin
                if (op == "#") begin
                    c = $fgetc(fd);
                    while (c != "\n" && c != -1) begin
                        c = $fgetc(fd);
                    end
                end else if ($fscanf(fd, "%h %h %h %h", f1, f2, f3, f4) != 4) begin
                    $display("malformed line in trace file");
                    $display("test failed");
                    $fatal(1, "bad trace");
                end else begin
                    run_op(op, f1, f2, f3, f4);
                end
            end
            $fclose(fd);
            $display("test passed");
            $finish;
        end
    end

endmodule

//--- com_reg_bank.f
design/com_pkg.sv
design/rstn_merge.sv
design/reg_access_decode.sv
design/cfg_reg_file.sv
design/status_reg_file.sv
design/spi_response.sv
design/com_reg_bank.sv
testbench/tb_com_reg_bank.sv

//--- testbench/com_reg_bank_trace.txt
# op f1 f2 f3 f4, all hex; W/R: state addr data crc (R gives expected), state 0 none 1 test 2 cfg 3 spi
# E: status1 status2 set bits, S: expected status1 status2, G: cfg index value, X: reset level, I: cycles
X 1 0 0 0
R 1 00 53 00
R 1 01 10 02
R 1 02 2B 17
R 1 03 FF E9
R 1 08 00 00
R 1 09 00 D3
R 1 0A 00 00
R 1 0B 00 2E
W 1 02 A5 3C
W 2 0B 7E 91
W 2 01 40 C8
G 1 A5 0 0
G 4 7E 0 0
G 0 40 0 0
R 3 02 A5 3C
R 3 0B 7E 91
R 3 01 40 C8
W 3 02 11 22
R 3 02 A5 3C
W 1 00 99 99
R 3 00 53 00
R 2 02 00 00
R 1 05 00 00
R 0 02 00 00
E C3 81 0 0
I 1 0 0 0
S C3 81 0 0
R 3 08 C3 00
W 3 08 41 00
S 82 81 0 0
E 00 01 0 0
W 3 0A 81 00
R 1 0A 01 00
W 1 01 01 5A
X 0 0 0 0
R 1 02 2B 17
R 1 01 11 02
W 1 03 66 77
W 1 01 00 00
X 1 0 0 0
R 3 03 FF E9
R 3 01 10 02
